// File: build.f
hdl/trail_pkg.sv
hdl/frame_timer.sv
hdl/game_fsm.sv
hdl/cycle_mover.sv
hdl/trail_writer.sv
hdl/trail_ram.sv
hdl/light_cycle_top.sv
tb/light_cycle_chk.sv
tb/tb_light_cycle.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_light_cycle
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_light_cycle.sv
// light cycle testbench
// directed games checked against a board model of the trail and crash rules
`timescale 1ns/100ps
`default_nettype none

module tb_light_cycle
	import trail_pkg::*;
();

	localparam int GRID_N     = 16;
	localparam int FRAME_CLKS = 64;
	localparam int FB_W       = 2 * GRID_N;
	localparam int WORDS      = 4 * GRID_N * GRID_N;
	localparam int CLK_PERIOD = 8;
	// four board sweeps and 31 frames, doubled for slack
	localparam int CLEARS      = 4;
	localparam int FRAMES      = 31;
	localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
		(CLEARS * (WORDS + 16) + FRAMES * (FRAME_CLKS + 16));

	logic        Clk;
	logic        rst_n;
	logic        start;
	logic        turn_blue;
	logic        turn_red;
	dir_t        turn_blue_dir;
	dir_t        turn_red_dir;
	logic        fb_we;
	fb_wr_t      fb_wr;
	game_state_t game_state;
	result_t     result;

	// board model, mirrors the write bus
	cell_code_t board [WORDS];
	fb_wr_t     wr_q [$];
	// expected heads and pending turns
	head_t      blue_m;
	head_t      red_m;
	dir_t       blue_pend;
	dir_t       red_pend;
	int         errors;
	int         tests;

	light_cycle_top #(.GRID_N(GRID_N), .FRAME_CLKS(FRAME_CLKS)) u_dut (
		.Clk(Clk), .rst_n(rst_n), .start(start), .turn_blue(turn_blue), .turn_red(turn_red),
		.turn_blue_dir(turn_blue_dir), .turn_red_dir(turn_red_dir),
		.fb_we(fb_we), .fb_wr(fb_wr), .game_state(game_state), .result(result)
	);

	bind light_cycle_top light_cycle_chk #(.GRID_N(GRID_N)) u_chk (
		.Clk(Clk), .rst_n(rst_n), .fb_we(fb_we), .fb_wr(fb_wr),
		.game_state(game_state), .step_done(step_done)
	);

	always #(CLK_PERIOD / 2) Clk = ~Clk;

	// bus sampled mid-cycle where it is settled
	always @(negedge Clk)
	begin
		if (fb_we === 1'b1)
		begin
			wr_q.push_back(fb_wr);
			if (fb_wr.addr < WORDS)
				board[int'(fb_wr.addr)] = fb_wr.code;
		end
	end

	function automatic dir_t opposite(dir_t d);
		case (d)
			DIR_DOWN:  return DIR_UP;
			DIR_UP:    return DIR_DOWN;
			DIR_RIGHT: return DIR_LEFT;
			default:   return DIR_RIGHT;
		endcase
	endfunction

	// one cell along d, turned on a change of direction
	function automatic head_t advance(head_t h, dir_t d);
		head_t n;
		int    dx;
		int    dy;
		dx = 0;
		dy = 0;
		case (d)
			DIR_DOWN:  dy = 1;
			DIR_UP:    dy = -1;
			DIR_RIGHT: dx = 1;
			default:   dx = -1;
		endcase
		n.x      = coord_t'(int'(h.x) + dx);
		n.y      = coord_t'(int'(h.y) + dy);
		n.dir    = d;
		n.turned = (d != h.dir);
		return n;
	endfunction

	// top-left word of the 2x2 block
	function automatic int cell_addr(head_t h);
		return 2 * int'(h.y) * FB_W + 2 * int'(h.x);
	endfunction

	function automatic logic crashes(head_t me, head_t other);
		if (int'(me.x) >= GRID_N || int'(me.y) >= GRID_N)
			return 1'b1;
		if (me.x == other.x && me.y == other.y)
			return 1'b1;
		return board[cell_addr(me)] != CODE_EMPTY;
	endfunction

	function automatic cell_code_t code_for(head_t h, logic red);
		if (h.turned)
			return CODE_CORNER;
		if (h.dir == DIR_UP || h.dir == DIR_DOWN)
			return red ? CODE_R_VERT : CODE_B_VERT;
		return red ? CODE_R_HORIZ : CODE_B_HORIZ;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err0);
		tests++;
		$display("%s finished, %0d errors", name, errors - err0);
	endtask

	task automatic pulse_start();
		@(posedge Clk);
		start <= 1'b1;
		@(posedge Clk);
		start <= 1'b0;
	endtask

	// strobe at a random point in the frame, reversals stay out of the model
	task automatic request_turn(input logic red, input dir_t d);
		repeat ($urandom_range(6, 1)) @(posedge Clk);
		if (red)
		begin
			turn_red     <= 1'b1;
			turn_red_dir <= d;
			if (d != opposite(red_m.dir))
				red_pend = d;
		end
		else
		begin
			turn_blue     <= 1'b1;
			turn_blue_dir <= d;
			if (d != opposite(blue_m.dir))
				blue_pend = d;
		end
		@(posedge Clk);
		turn_red  <= 1'b0;
		turn_blue <= 1'b0;
	endtask

	task automatic wait_for_state(input game_state_t st);
		while (game_state != st)
			@(posedge Clk);
	endtask

	// start, check the empty sweep, heads back to start
	task automatic new_game();
		int bad;
		bad = 0;
		if (wr_q.size() != 0)
			report_mismatch($sformatf("%0d writes before start", wr_q.size()));
		wr_q.delete();
		pulse_start();
		@(posedge Clk);
		if (game_state != ST_CLEAR || result != RES_NONE)
			report_mismatch($sformatf("after start state %0d result %0d", game_state, result));
		wait_for_state(ST_PLAY);
		if (wr_q.size() != WORDS)
			report_mismatch($sformatf("clear gave %0d writes, expected %0d", wr_q.size(), WORDS));
		for (int i = 0; i < wr_q.size(); i++)
			if (int'(wr_q[i].addr) != i || wr_q[i].code != CODE_EMPTY)
				bad++;
		if (bad != 0)
			report_mismatch($sformatf("%0d clear writes out of order or not empty", bad));
		wr_q.delete();
		blue_m    = '{x: coord_t'(2), y: coord_t'(GRID_N / 2), dir: DIR_RIGHT, turned: 1'b0};
		red_m     = '{x: coord_t'(GRID_N - 3), y: coord_t'(GRID_N / 2), dir: DIR_LEFT,
			turned: 1'b0};
		blue_pend = DIR_RIGHT;
		red_pend  = DIR_LEFT;
	endtask

	// one frame, eight trail words or game over
	task automatic play_step(output logic over);
		head_t      nb;
		head_t      nr;
		head_t      h;
		logic       cb;
		logic       cr;
		result_t    exp_res;
		fb_wr_t     got;
		cell_code_t exp_code;
		int         exp_addr;
		int         n;
		nb   = advance(blue_m, blue_pend);
		nr   = advance(red_m, red_pend);
		cb   = crashes(nb, nr);
		cr   = crashes(nr, nb);
		over = cb || cr;
		if (wr_q.size() != 0)
			report_mismatch($sformatf("%0d stray writes between steps", wr_q.size()));
		wr_q.delete();
		if (over)
		begin
			if (cb && cr)
				exp_res = RES_DRAW;
			else if (cb)
				exp_res = RES_RED_WINS;
			else
				exp_res = RES_BLUE_WINS;
			n = 0;
			while (game_state != ST_OVER && n < 2 * FRAME_CLKS)
			begin
				@(posedge Clk);
				n++;
			end
			repeat (12) @(posedge Clk);
			if (game_state != ST_OVER || result != exp_res)
				report_mismatch($sformatf("crash step gave state %0d result %0d, expected result %0d",
					game_state, result, exp_res));
			if (wr_q.size() != 0)
				report_mismatch($sformatf("%0d writes on a crash step", wr_q.size()));
		end
		else
		begin
			while (wr_q.size() < 8)
				@(posedge Clk);
			for (int i = 0; i < 8; i++)
			begin
				h        = (i < 4) ? nb : nr;
				// order a, a+FB_W, a+1, a+FB_W+1
				exp_addr = cell_addr(h) + (i % 4) / 2 + ((i % 4) % 2) * FB_W;
				exp_code = code_for(h, i >= 4);
				got      = wr_q.pop_front();
				if (int'(got.addr) != exp_addr || got.code != exp_code)
					report_mismatch($sformatf("word %0d addr %0d code %0d, expected addr %0d code %0d",
						i, got.addr, got.code, exp_addr, exp_code));
			end
			// state settles two edges after the last word
			repeat (2) @(posedge Clk);
			if (game_state != ST_PLAY)
				report_mismatch($sformatf("left play on a clean step, state %0d", game_state));
		end
		blue_m = nb;
		red_m  = nr;
	endtask

	task automatic test_reset_idle();
		int err0;
		err0 = errors;
		if (game_state != ST_IDLE || result != RES_NONE || fb_we !== 1'b0)
			report_mismatch($sformatf("after reset state %0d result %0d", game_state, result));
		repeat (3 * FRAME_CLKS) @(posedge Clk);
		if (wr_q.size() != 0 || game_state != ST_IDLE)
			report_mismatch($sformatf("idle gave %0d writes, state %0d", wr_q.size(), game_state));
		finish_test("reset_idle", err0);
	endtask

	task automatic test_clear_straight();
		int   err0;
		logic over;
		err0 = errors;
		new_game();
		repeat (2)
		begin
			play_step(over);
			if (over)
				report_mismatch("crash on a straight run");
		end
		finish_test("clear_straight", err0);
	endtask

	// continues the first game, blue at (4,8) and red at (11,8)
	task automatic test_turns();
		int   err0;
		logic over;
		logic any_over;
		err0 = errors;
		request_turn(1'b0, DIR_UP);
		// reversal, dropped
		request_turn(1'b1, DIR_RIGHT);
		play_step(any_over);
		request_turn(1'b1, DIR_UP);
		// last strobe wins
		request_turn(1'b1, DIR_DOWN);
		play_step(over);
		any_over = any_over || over;
		request_turn(1'b0, DIR_DOWN);
		play_step(over);
		any_over = any_over || over;
		if (any_over)
			report_mismatch("crash while turning");
		finish_test("turns", err0);
	endtask

	task automatic test_crashes();
		int   err0;
		int   steps;
		logic over;
		err0 = errors;
		// blue climbs into the top wall, red goes left along row 10
		request_turn(1'b1, DIR_LEFT);
		over  = 1'b0;
		steps = 0;
		while (!over && steps < 10)
		begin
			play_step(over);
			steps++;
		end
		if (!over || result != RES_RED_WINS)
			report_mismatch($sformatf("wall crash gave result %0d", result));
		// red drops into row 8 behind blue
		new_game();
		request_turn(1'b1, DIR_UP);
		play_step(over);
		request_turn(1'b1, DIR_LEFT);
		repeat (5)
		begin
			if (!over)
				play_step(over);
		end
		request_turn(1'b1, DIR_DOWN);
		if (!over)
			play_step(over);
		if (!over || result != RES_BLUE_WINS)
			report_mismatch($sformatf("trail crash gave result %0d", result));
		finish_test("crashes", err0);
	endtask

	task automatic test_draw_restart();
		int   err0;
		int   steps;
		logic over;
		err0  = errors;
		new_game();
		over  = 1'b0;
		steps = 0;
		while (!over && steps < GRID_N)
		begin
			play_step(over);
			steps++;
		end
		if (!over || result != RES_DRAW)
			report_mismatch($sformatf("head-on run gave result %0d", result));
		// fresh board, heads from the start cells again
		new_game();
		play_step(over);
		if (over)
			report_mismatch("crash on the first step after restart");
		finish_test("draw_restart", err0);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		Clk           = 1'b0;
		rst_n         = 1'b0;
		start         = 1'b0;
		turn_blue     = 1'b0;
		turn_red      = 1'b0;
		turn_blue_dir = DIR_DOWN;
		turn_red_dir  = DIR_DOWN;
		blue_pend     = DIR_RIGHT;
		red_pend      = DIR_LEFT;
		blue_m        = '0;
		red_m         = '0;
		errors        = 0;
		tests         = 0;
		void'($urandom(74));
		repeat (2) @(posedge Clk);
		rst_n <= 1'b1;
		@(posedge Clk);
		test_reset_idle();
		test_clear_straight();
		test_turns();
		test_crashes();
		test_draw_restart();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/light_cycle_chk.sv
// write bus and game state checks
// bound into the light cycle top level
`timescale 1ns/100ps
`default_nettype none

module light_cycle_chk
	import trail_pkg::*;
#(
	parameter int GRID_N = 16
) (
	input logic        Clk,
	input logic        rst_n,
	input logic        fb_we,
	input fb_wr_t      fb_wr,
	input game_state_t game_state,
	input logic        step_done
);

	localparam int WORDS = 4 * GRID_N * GRID_N;

	// board writes only while clearing or playing
	a_we_in_game: assert property (@(posedge Clk) disable iff (!rst_n)
		fb_we |-> (game_state == ST_CLEAR || game_state == ST_PLAY))
		else $error("frame buffer write in state %0d", game_state);

	// every write lands on the board
	a_addr_range: assert property (@(posedge Clk) disable iff (!rst_n)
		fb_we |-> (fb_wr.addr < fb_addr_t'(WORDS)))
		else $error("write address %0d off the board", fb_wr.addr);

	// step ends after its last word
	a_done_quiet: assert property (@(posedge Clk) disable iff (!rst_n)
		!(step_done && fb_we))
		else $error("step_done together with a write");

endmodule

`default_nettype wire

// File: hdl/light_cycle_top.sv
// light cycle trail and collision subsystem
// frame timer, game FSM, mover, trail writer and shadow RAM
`timescale 1ns/100ps
`default_nettype none

module light_cycle_top
	import trail_pkg::*;
#(
	parameter int GRID_N     = 16,
	parameter int FRAME_CLKS = 64
) (
	input  logic        Clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic        turn_blue,
	input  logic        turn_red,
	input  dir_t        turn_blue_dir,
	input  dir_t        turn_red_dir,
	output logic        fb_we,
	output fb_wr_t      fb_wr,
	output game_state_t game_state,
	output result_t     result
);

	logic       play, frame_tick, moved, clear_req;
	logic       clear_done, step_done, crash_blue, crash_red;
	head_t      blue_head, red_head;
	fb_addr_t   rd_addr;
	cell_code_t rd_code;

	assign play = (game_state == ST_PLAY);

	frame_timer #(.FRAME_CLKS(FRAME_CLKS)) u_timer (
		.Clk(Clk), .rst_n(rst_n), .play(play), .frame_tick(frame_tick)
	);

	game_fsm u_fsm (
		.Clk(Clk), .rst_n(rst_n), .start(start),
		.clear_done(clear_done), .step_done(step_done),
		.crash_blue(crash_blue), .crash_red(crash_red),
		.clear_req(clear_req), .game_state(game_state), .result(result)
	);

	cycle_mover #(.GRID_N(GRID_N)) u_mover (
		.Clk(Clk), .rst_n(rst_n), .clear_req(clear_req), .frame_tick(frame_tick),
		.turn_blue(turn_blue), .turn_red(turn_red),
		.turn_blue_dir(turn_blue_dir), .turn_red_dir(turn_red_dir),
		.blue_head(blue_head), .red_head(red_head), .moved(moved)
	);

	// writes go to the shadow RAM and out to the frame buffer
	trail_writer #(.GRID_N(GRID_N)) u_writer (
		.Clk(Clk), .rst_n(rst_n), .clear_req(clear_req), .moved(moved),
		.blue_head(blue_head), .red_head(red_head), .rd_code(rd_code),
		.rd_addr(rd_addr), .fb_we(fb_we), .fb_wr(fb_wr),
		.clear_done(clear_done), .step_done(step_done),
		.crash_blue(crash_blue), .crash_red(crash_red)
	);

	trail_ram #(.GRID_N(GRID_N)) u_ram (
		.Clk(Clk), .we(fb_we), .wr(fb_wr), .rd_addr(rd_addr), .rd_code(rd_code)
	);

endmodule

`default_nettype wire

// File: hdl/trail_ram.sv
// shadow trail RAM
// same words as the frame buffer, one write port and one registered read port
`timescale 1ns/100ps
`default_nettype none

module trail_ram
	import trail_pkg::*;
#(
	parameter int GRID_N = 16
) (
	input  logic       Clk,
	input  logic       we,
	input  fb_wr_t     wr,
	input  fb_addr_t   rd_addr,
	output cell_code_t rd_code
);

	localparam int WORDS = 4 * GRID_N * GRID_N;
	localparam int AW = $clog2(WORDS);

	cell_code_t mem [WORDS];

	always_ff @(posedge Clk)
	begin
		if (we && (wr.addr < fb_addr_t'(WORDS)))
			mem[wr.addr[AW-1:0]] <= wr.code;
		// off-board reads return empty, the writer flags those itself
		if (rd_addr < fb_addr_t'(WORDS))
			rd_code <= mem[rd_addr[AW-1:0]];
		else
			rd_code <= CODE_EMPTY;
	end

endmodule

`default_nettype wire

// File: hdl/trail_writer.sv
// trail writer
// board clear sweep, crash lookup and the 2x2 trail writes per step
`timescale 1ns/100ps
`default_nettype none

module trail_writer
	import trail_pkg::*;
#(
	parameter int GRID_N = 16
) (
	input  logic       Clk,
	input  logic       rst_n,
	input  logic       clear_req,
	input  logic       moved,
	input  head_t      blue_head,
	input  head_t      red_head,
	input  cell_code_t rd_code,
	output fb_addr_t   rd_addr,
	output logic       fb_we,
	output fb_wr_t     fb_wr,
	output logic       clear_done,
	output logic       step_done,
	output logic       crash_blue,
	output logic       crash_red
);

	localparam int FB_W = 2 * GRID_N;
	localparam int WORDS = 4 * GRID_N * GRID_N;

	logic       clr_active;
	fb_addr_t   clr_addr;
	logic       step_active;
	logic [3:0] step_cnt;
	cell_code_t blue_code;
	fb_addr_t   blue_a, red_a, base_a, word_a;
	head_t      wr_head;
	logic [1:0] word_idx;
	logic       is_red, oob_blue, oob_red, same_cell, hit_blue, hit_red;

	function automatic fb_addr_t top_left(head_t h);
		return fb_addr_t'(h.y) * fb_addr_t'(2 * FB_W) + fb_addr_t'(h.x) * fb_addr_t'(2);
	endfunction

	function automatic cell_code_t trail_code(head_t h, logic red);
		logic horiz;
		horiz = (h.dir == DIR_RIGHT) || (h.dir == DIR_LEFT);
		if (h.turned)
			return CODE_CORNER;
		if (red)
			return horiz ? CODE_R_HORIZ : CODE_R_VERT;
		return horiz ? CODE_B_HORIZ : CODE_B_VERT;
	endfunction

	assign blue_a = top_left(blue_head);
	assign red_a  = top_left(red_head);

	// cycle 0 reads blue, cycle 1 reads red
	assign rd_addr = (step_cnt == 4'd1) ? red_a : blue_a;

	// crash check, red's word arrives in cycle 2
	assign oob_blue  = (blue_head.x >= coord_t'(GRID_N)) || (blue_head.y >= coord_t'(GRID_N));
	assign oob_red   = (red_head.x >= coord_t'(GRID_N)) || (red_head.y >= coord_t'(GRID_N));
	assign same_cell = (blue_head.x == red_head.x) && (blue_head.y == red_head.y);
	assign hit_blue  = oob_blue || (blue_code != CODE_EMPTY) || same_cell;
	assign hit_red   = oob_red || (rd_code != CODE_EMPTY) || same_cell;

	// cycles 3..6 blue, 7..10 red
	assign is_red   = (step_cnt >= 4'd7);
	assign wr_head  = is_red ? red_head : blue_head;
	assign base_a   = is_red ? red_a : blue_a;
	// (cnt - 3) mod 4
	assign word_idx = step_cnt[1:0] + 2'd1;

	// order a, a+FB_W, a+1, a+FB_W+1
	always_comb
	begin
		case (word_idx)
			2'd0:    word_a = base_a;
			2'd1:    word_a = base_a + fb_addr_t'(FB_W);
			2'd2:    word_a = base_a + fb_addr_t'(1);
			default: word_a = base_a + fb_addr_t'(FB_W + 1);
		endcase
	end

	assign fb_we = clr_active || (step_active && (step_cnt >= 4'd3));
	assign fb_wr = clr_active ? '{addr: clr_addr, code: CODE_EMPTY}
		: '{addr: word_a, code: trail_code(wr_head, is_red)};

	always_ff @(posedge Clk)
	begin
		if (step_active && (step_cnt == 4'd1))
			blue_code <= rd_code;
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			clr_active  <= 1'b0;
			clr_addr    <= '0;
			step_active <= 1'b0;
			step_cnt    <= '0;
			clear_done  <= 1'b0;
			step_done   <= 1'b0;
			crash_blue  <= 1'b0;
			crash_red   <= 1'b0;
		end
		else
		begin
			clear_done <= 1'b0;
			step_done  <= 1'b0;
			// clear sweep, one word per cycle
			if (clear_req)
			begin
				clr_active <= 1'b1;
				clr_addr   <= '0;
			end
			else if (clr_active)
			begin
				if (clr_addr == fb_addr_t'(WORDS - 1))
				begin
					clr_active <= 1'b0;
					clear_done <= 1'b1;
				end
				else
					clr_addr <= clr_addr + 1'b1;
			end
			// step sequencer
			if (clear_req)
				step_active <= 1'b0;
			else if (moved)
			begin
				step_active <= 1'b1;
				step_cnt    <= '0;
				crash_blue  <= 1'b0;
				crash_red   <= 1'b0;
			end
			else if (step_active)
			begin
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == 4'd2)
				begin
					crash_blue <= hit_blue;
					crash_red  <= hit_red;
					// crash ends the step before any write
					if (hit_blue || hit_red)
					begin
						step_active <= 1'b0;
						step_done   <= 1'b1;
					end
				end
				if (step_cnt == 4'd10)
				begin
					step_active <= 1'b0;
					step_done   <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/cycle_mover.sv
// light cycle mover
// holds both heads, latches turn requests, steps one cell per frame tick
`timescale 1ns/100ps
`default_nettype none

module cycle_mover
	import trail_pkg::*;
#(
	parameter int GRID_N = 16
) (
	input  logic  Clk,
	input  logic  rst_n,
	input  logic  clear_req,
	input  logic  frame_tick,
	input  logic  turn_blue,
	input  logic  turn_red,
	input  dir_t  turn_blue_dir,
	input  dir_t  turn_red_dir,
	output head_t blue_head,
	output head_t red_head,
	output logic  moved
);

	localparam coord_t START_Y = coord_t'(GRID_N / 2);
	localparam head_t BLUE_START = '{x: coord_t'(2), y: START_Y, dir: DIR_RIGHT, turned: 1'b0};
	localparam head_t RED_START = '{x: coord_t'(GRID_N - 3), y: START_Y, dir: DIR_LEFT,
		turned: 1'b0};

	dir_t blue_pend;
	dir_t red_pend;

	// keep the request unless it reverses the reference direction
	function automatic dir_t next_pend(logic strobe, dir_t req, dir_t pend, dir_t ref_dir);
		if (strobe && (req != dir_t'(ref_dir ^ 2'b01)))
			return req;
		return pend;
	endfunction

	// one cell along d, turned marks a corner
	function automatic head_t step_head(head_t h, dir_t d);
		head_t n;
		n        = h;
		n.dir    = d;
		n.turned = (d != h.dir);
		case (d)
			DIR_DOWN:  n.y = h.y + coord_t'(1);
			DIR_UP:    n.y = h.y - coord_t'(1);
			DIR_RIGHT: n.x = h.x + coord_t'(1);
			default:   n.x = h.x - coord_t'(1);
		endcase
		return n;
	endfunction

	always_ff @(posedge Clk)
	begin
		if (!rst_n || clear_req)
		begin
			blue_head <= BLUE_START;
			red_head  <= RED_START;
			blue_pend <= DIR_RIGHT;
			red_pend  <= DIR_LEFT;
			moved     <= 1'b0;
		end
		else
		begin
			moved <= frame_tick;
			if (frame_tick)
			begin
				blue_head <= step_head(blue_head, blue_pend);
				red_head  <= step_head(red_head, red_pend);
			end
			// on a tick the pending dir is the one being committed
			blue_pend <= next_pend(turn_blue, turn_blue_dir, blue_pend,
				frame_tick ? blue_pend : blue_head.dir);
			red_pend  <= next_pend(turn_red, turn_red_dir, red_pend,
				frame_tick ? red_pend : red_head.dir);
		end
	end

endmodule

`default_nettype wire

// File: hdl/game_fsm.sv
// game state machine
// idle, clear, play and over, plus the winner from the crash flags
`timescale 1ns/100ps
`default_nettype none

module game_fsm
	import trail_pkg::*;
(
	input  logic        Clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic        clear_done,
	input  logic        step_done,
	input  logic        crash_blue,
	input  logic        crash_red,
	output logic        clear_req,
	output game_state_t game_state,
	output result_t     result
);

	result_t outcome;

	// who wins when at least one head crashed
	always_comb
	begin
		case ({crash_blue, crash_red})
			2'b11:   outcome = RES_DRAW;
			2'b10:   outcome = RES_RED_WINS;
			default: outcome = RES_BLUE_WINS;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			game_state <= ST_IDLE;
			result     <= RES_NONE;
			clear_req  <= 1'b0;
		end
		else
		begin
			clear_req <= 1'b0;
			case (game_state)
				ST_IDLE, ST_OVER:
					if (start)
					begin
						// new game, wipe board and old result
						game_state <= ST_CLEAR;
						result     <= RES_NONE;
						clear_req  <= 1'b1;
					end
				ST_CLEAR:
					if (clear_done)
						game_state <= ST_PLAY;
				ST_PLAY:
					// clean steps keep playing
					if (step_done && (crash_blue || crash_red))
					begin
						game_state <= ST_OVER;
						result     <= outcome;
					end
				default:
					game_state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/frame_timer.sv
// frame timer
// one-cycle frame tick every FRAME_CLKS clocks while the game is in play
`timescale 1ns/100ps
`default_nettype none

module frame_timer #(
	parameter int FRAME_CLKS = 64
) (
	input  logic Clk,
	input  logic rst_n,
	input  logic play,
	output logic frame_tick
);

	localparam int CNT_W = $clog2(FRAME_CLKS);
	localparam logic [CNT_W-1:0] LOAD = CNT_W'(FRAME_CLKS - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			cnt        <= LOAD;
			frame_tick <= 1'b0;
		end
		else
		begin
			frame_tick <= 1'b0;
			// held at reload outside play, first tick a full frame in
			if (!play)
				cnt <= LOAD;
			else if (cnt == '0)
			begin
				cnt        <= LOAD;
				frame_tick <= 1'b1;
			end
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/trail_pkg.sv
// light cycle game types
// widths, trail codes, directions, game state and bus structs
`default_nettype none

package trail_pkg;

	// grid coordinate, wraps past zero on purpose
	typedef logic [7:0] coord_t;
	// frame buffer word address
	typedef logic [19:0] fb_addr_t;
	// trail code stored per word
	typedef logic [2:0] cell_code_t;

	localparam cell_code_t CODE_EMPTY   = 3'd0;
	localparam cell_code_t CODE_B_HORIZ = 3'd1;
	localparam cell_code_t CODE_B_VERT  = 3'd2;
	localparam cell_code_t CODE_R_HORIZ = 3'd3;
	localparam cell_code_t CODE_R_VERT  = 3'd4;
	localparam cell_code_t CODE_CORNER  = 3'd5;

	// opposite directions differ only in bit 0
	typedef enum logic [1:0] {DIR_DOWN, DIR_UP, DIR_RIGHT, DIR_LEFT} dir_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		dir_t   dir;
		logic   turned;
	} head_t;

	typedef struct packed {
		fb_addr_t   addr;
		cell_code_t code;
	} fb_wr_t;

	typedef enum logic [1:0] {ST_IDLE, ST_CLEAR, ST_PLAY, ST_OVER} game_state_t;

	typedef enum logic [1:0] {RES_NONE, RES_BLUE_WINS, RES_RED_WINS, RES_DRAW} result_t;

endpackage

`default_nettype wire
